/* logic/insn_exec_config.svh */
`ifndef INSN_EXEC_CONFIG_SVH
`define INSN_EXEC_CONFIG_SVH

// Datapath widths
`define DATA_W        16    // Register and stack word
`define SP_W          8     // Stack word address

// Stack pointer value after reset
`define STACK_BASE    16

// Byte buffer depth, also the sender's starting credits
`define BYTE_CREDITS  2

// Display scan
`define SCAN_DIV      16    // Cycles per digit, short for simulation
`define NUM_DIGITS    4

`endif

/* logic/insn_exec_pkg.sv */
`include "insn_exec_config.svh"

package insn_exec_pkg;

    typedef logic [`DATA_W-1:0] word_t;     // Register or stack word
    typedef logic [7:0]         byte_t;     // One stream byte
    typedef logic [3:0]         reg_idx_t;  // r0..r15
    typedef logic [`SP_W-1:0]   sp_t;       // Stack word address
    typedef logic [15:0]        insn_t;     // op:2 mod:6 src:4 dst:4
    typedef logic [7:0]         seg_t;      // Active low, dp in bit 7

    // Op family in insn[15:14]
    typedef enum logic [1:0] {
        OP_R = 2'b00,   // Register/ALU
        OP_M = 2'b01,   // Memory
        OP_J = 2'b10,   // Jump, not executed
        OP_X = 2'b11    // Extended, not executed
    } opfam_e;

    // R-family modifiers
    typedef enum logic [5:0] {
        RMOD_MOV  = 6'b000000,
        RMOD_ADD  = 6'b000001,
        RMOD_XOR  = 6'b000101,
        RMOD_ADDI = 6'b010000   // Immediate sits in the src field
    } rmod_e;

    // M-family modifiers
    typedef enum logic [5:0] {
        MMOD_PUSH = 6'b000010,
        MMOD_POP  = 6'b000011
    } mmod_e;

    // Register write source
    typedef enum logic [2:0] {
        WSEL_MOV,
        WSEL_ADD,
        WSEL_XOR,
        WSEL_ADDI,
        WSEL_POP    // Stack read data
    } wr_sel_e;

    typedef enum logic {
        ST_FETCH,
        ST_POP_WAIT
    } exec_state_e;

    // One request to the stack memory
    typedef struct packed {
        logic  valid;
        logic  write;   // 1 push, 0 pop
        sp_t   addr;
        word_t wdata;
    } stack_req_t;

endpackage

/* logic/insn_assembler.sv */
`timescale 1ns/10ps
`include "insn_exec_config.svh"

module insn_assembler (
    input  logic                 clk_100mhz,
    input  logic                 rst_n,
    input  logic                 byte_valid,
    input  insn_exec_pkg::byte_t byte_data,
    input  logic                 insn_take,
    output logic                 insn_valid,
    output insn_exec_pkg::insn_t insn,
    output logic [1:0]           credit_return
);
    import insn_exec_pkg::*;

    byte_t      hi_byte_q;      // First byte of the pair
    byte_t      lo_byte_q;      // Second byte
    logic [1:0] fill_q;         // Bytes held, 0..2
    logic       consume;

    assign insn_valid = (fill_q == 2'd2);   // Pair complete
    assign insn       = {hi_byte_q, lo_byte_q};  // High byte first
    assign consume    = insn_valid && insn_take;

    // Both credits go back with the pair
    assign credit_return = consume ? 2'(`BYTE_CREDITS) : 2'd0;

    // Occupancy
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            fill_q <= 2'd0;
        end else if (consume) begin
            fill_q <= byte_valid ? 2'd1 : 2'd0;  // A byte in the same cycle starts a new pair
        end else if (byte_valid) begin
            fill_q <= fill_q + 2'd1;    // Credits keep this below 3
        end
    end

    // Byte storage
    always_ff @(posedge clk_100mhz) begin
        if (byte_valid) begin
            if (consume || fill_q == 2'd0) begin
                hi_byte_q <= byte_data;
            end else begin
                lo_byte_q <= byte_data;
            end
        end
    end

endmodule

/* logic/exec_control.sv */
`timescale 1ns/10ps
`include "insn_exec_config.svh"

module exec_control (
    input  logic                      clk_100mhz,
    input  logic                      rst_n,
    input  logic                      insn_valid,
    input  insn_exec_pkg::insn_t      insn,
    output logic                      insn_take,
    output insn_exec_pkg::reg_idx_t   rf_rd_a,
    output insn_exec_pkg::reg_idx_t   rf_rd_b,
    output logic                      rf_wr_en,
    output insn_exec_pkg::reg_idx_t   rf_wr_idx,
    output insn_exec_pkg::wr_sel_e    rf_wr_sel,
    input  insn_exec_pkg::word_t      rf_rd_a_data,
    output insn_exec_pkg::stack_req_t stack_req,
    input  logic                      rsp_valid,
    input  insn_exec_pkg::word_t      rsp_data,
    output insn_exec_pkg::word_t      pop_data
);
    import insn_exec_pkg::*;

    exec_state_e state_q;
    sp_t         sp_q;          // Next free stack word
    reg_idx_t    pop_dst_q;     // Destination held across the pop wait
    opfam_e      op;
    logic [5:0]  mod;
    reg_idx_t    src;
    reg_idx_t    dst;
    logic        r_known;       // Legal R-family mod
    wr_sel_e     r_sel;
    logic        is_push;
    logic        is_pop;

    // Field split
    assign op  = opfam_e'(insn[15:14]);
    assign mod = insn[13:8];
    assign src = insn[7:4];
    assign dst = insn[3:0];

    // Every valid word is taken in FETCH, unknown ones just vanish
    assign insn_take = (state_q == ST_FETCH) && insn_valid;

    always_comb begin
        r_known = 1'b0;
        r_sel   = WSEL_MOV;
        is_push = 1'b0;
        is_pop  = 1'b0;
        case (op)
            OP_R: begin
                r_known = 1'b1;
                case (mod)
                    RMOD_MOV:  r_sel = WSEL_MOV;
                    RMOD_ADD:  r_sel = WSEL_ADD;
                    RMOD_XOR:  r_sel = WSEL_XOR;
                    RMOD_ADDI: r_sel = WSEL_ADDI;
                    default:   r_known = 1'b0;
                endcase
            end
            OP_M: begin
                is_push = (mod == MMOD_PUSH);
                is_pop  = (mod == MMOD_POP);
            end
            OP_J, OP_X: begin
                r_known = 1'b0;     // Reserved families
            end
            default: begin
                r_known = 1'b0;
            end
        endcase
    end

    // Register file side
    assign rf_rd_a   = dst;     // Also the push source
    assign rf_rd_b   = src;
    assign rf_wr_en  = (insn_take && r_known) || (state_q == ST_POP_WAIT && rsp_valid);
    assign rf_wr_idx = (state_q == ST_POP_WAIT) ? pop_dst_q : dst;
    assign rf_wr_sel = (state_q == ST_POP_WAIT) ? WSEL_POP : r_sel;
    assign pop_data  = rsp_data;

    // Stack side, push at sp, pop at sp-1
    assign stack_req.valid = insn_take && (is_push || is_pop);
    assign stack_req.write = is_push;
    assign stack_req.addr  = is_push ? sp_q : sp_q - 1'b1;
    assign stack_req.wdata = rf_rd_a_data;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_FETCH;
            sp_q    <= sp_t'(`STACK_BASE);
        end else begin
            case (state_q)
                ST_FETCH: begin
                    if (insn_take && is_push) begin
                        sp_q <= sp_q + 1'b1;
                    end
                    if (insn_take && is_pop) begin
                        sp_q    <= sp_q - 1'b1;
                        state_q <= ST_POP_WAIT;     // Read data next cycle
                    end
                end
                ST_POP_WAIT: begin
                    if (rsp_valid) begin
                        state_q <= ST_FETCH;
                    end
                end
                default: state_q <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (insn_take && is_pop) begin
            pop_dst_q <= dst;
        end
    end

endmodule

/* logic/reg_file_alu.sv */
`timescale 1ns/10ps

module reg_file_alu (
    input  logic                    clk_100mhz,
    input  logic                    rst_n,
    input  insn_exec_pkg::reg_idx_t rd_a,
    input  insn_exec_pkg::reg_idx_t rd_b,
    input  logic                    wr_en,
    input  insn_exec_pkg::reg_idx_t wr_idx,
    input  insn_exec_pkg::wr_sel_e  wr_sel,
    input  logic [3:0]              imm,
    input  insn_exec_pkg::word_t    pop_data,
    output insn_exec_pkg::word_t    rd_a_data,
    output insn_exec_pkg::word_t    r3
);
    import insn_exec_pkg::*;

    word_t regs_q [16];     // r0..r15
    word_t rd_b_data;
    word_t wr_val;

    assign rd_a_data = regs_q[rd_a];    // dst operand
    assign rd_b_data = regs_q[rd_b];    // src operand
    assign r3        = regs_q[3];       // Display register

    // Write-path ALU, sums wrap at 16 bits
    always_comb begin
        case (wr_sel)
            WSEL_MOV:  wr_val = rd_b_data;
            WSEL_ADD:  wr_val = rd_a_data + rd_b_data;
            WSEL_XOR:  wr_val = rd_a_data ^ rd_b_data;
            WSEL_ADDI: wr_val = rd_a_data + word_t'(imm);  // Zero-extended
            WSEL_POP:  wr_val = pop_data;
            default:   wr_val = rd_a_data;
        endcase
    end

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wr_idx] <= wr_val;
        end
    end

endmodule

/* logic/stack_ram.sv */
`timescale 1ns/10ps
`include "insn_exec_config.svh"

module stack_ram (
    input  logic                      clk_100mhz,
    input  insn_exec_pkg::stack_req_t req,
    output logic                      rsp_valid,
    output insn_exec_pkg::word_t      rsp_data
);
    import insn_exec_pkg::*;

    localparam int DEPTH = 2 ** `SP_W;

    word_t mem [DEPTH];     // Stack words

    // Push lands in the request cycle
    always_ff @(posedge clk_100mhz) begin
        if (req.valid && req.write) begin
            mem[req.addr] <= req.wdata;
        end
    end

    // Pop data one cycle after the request
    always_ff @(posedge clk_100mhz) begin
        rsp_valid <= req.valid && !req.write;
        if (req.valid && !req.write) begin
            rsp_data <= mem[req.addr];
        end
    end

endmodule

/* logic/seg_display.sv */
`timescale 1ns/10ps
`include "insn_exec_config.svh"

module seg_display (
    input  logic                    clk_100mhz,
    input  logic                    rst_n,
    input  insn_exec_pkg::word_t    value,
    output logic [`NUM_DIGITS-1:0]  seg_sel,
    output insn_exec_pkg::seg_t     seg_data
);
    import insn_exec_pkg::*;

    localparam int DIV_W = $clog2(`SCAN_DIV);
    localparam int DIG_W = $clog2(`NUM_DIGITS);

    logic [DIV_W-1:0] div_q;    // Cycles on the current digit
    logic [DIG_W-1:0] dig_q;    // 0 is leftmost
    logic [3:0]       nibble;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= '0;
            dig_q <= '0;
        end else if (div_q == DIV_W'(`SCAN_DIV - 1)) begin
            div_q <= '0;
            if (dig_q == DIG_W'(`NUM_DIGITS - 1)) begin
                dig_q <= '0;
            end else begin
                dig_q <= dig_q + 1'b1;
            end
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    // One-cold select
    assign seg_sel = ~(`NUM_DIGITS'(1) << dig_q);

    // Digit 0 carries the top nibble
    assign nibble = value[(`NUM_DIGITS - 1 - dig_q) * 4 +: 4];

    // Hex font, gfedcba active low, dp held off
    always_comb begin
        case (nibble)
            4'h0: seg_data = 8'hC0;
            4'h1: seg_data = 8'hF9;
            4'h2: seg_data = 8'hA4;
            4'h3: seg_data = 8'hB0;
            4'h4: seg_data = 8'h99;
            4'h5: seg_data = 8'h92;
            4'h6: seg_data = 8'h82;
            4'h7: seg_data = 8'hF8;
            4'h8: seg_data = 8'h80;
            4'h9: seg_data = 8'h90;
            4'hA: seg_data = 8'h88;
            4'hB: seg_data = 8'h83;     // Lower-case b
            4'hC: seg_data = 8'hC6;
            4'hD: seg_data = 8'hA1;     // Lower-case d
            4'hE: seg_data = 8'h86;
            4'hF: seg_data = 8'h8E;
            default: seg_data = 8'hFF;  // Blank
        endcase
    end

endmodule

/* logic/insn_exec_top.sv */
`timescale 1ns/10ps
`include "insn_exec_config.svh"

module insn_exec_top (
    input  logic                    clk_100mhz,
    input  logic                    rst_n,
    input  logic                    byte_valid,
    input  insn_exec_pkg::byte_t    byte_data,
    output logic [1:0]              credit_return,
    output logic [`NUM_DIGITS-1:0]  seg_sel,
    output insn_exec_pkg::seg_t     seg_data
);
    import insn_exec_pkg::*;

    logic       insn_valid;
    insn_t      insn;
    logic       insn_take;
    reg_idx_t   rf_rd_a;
    reg_idx_t   rf_rd_b;
    logic       rf_wr_en;
    reg_idx_t   rf_wr_idx;
    wr_sel_e    rf_wr_sel;
    word_t      rf_rd_a_data;
    word_t      pop_data;
    word_t      r3;
    stack_req_t stack_req;
    logic       rsp_valid;
    word_t      rsp_data;

    insn_assembler u_insn_assembler (
        .clk_100mhz    (clk_100mhz),
        .rst_n         (rst_n),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .insn_take     (insn_take),
        .insn_valid    (insn_valid),
        .insn          (insn),
        .credit_return (credit_return)
    );

    exec_control u_exec_control (
        .clk_100mhz   (clk_100mhz),
        .rst_n        (rst_n),
        .insn_valid   (insn_valid),
        .insn         (insn),
        .insn_take    (insn_take),
        .rf_rd_a      (rf_rd_a),
        .rf_rd_b      (rf_rd_b),
        .rf_wr_en     (rf_wr_en),
        .rf_wr_idx    (rf_wr_idx),
        .rf_wr_sel    (rf_wr_sel),
        .rf_rd_a_data (rf_rd_a_data),
        .stack_req    (stack_req),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .pop_data     (pop_data)
    );

    reg_file_alu u_reg_file_alu (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .rd_a       (rf_rd_a),
        .rd_b       (rf_rd_b),
        .wr_en      (rf_wr_en),
        .wr_idx     (rf_wr_idx),
        .wr_sel     (rf_wr_sel),
        .imm        (insn[7:4]),    // ADDI immediate in the src field
        .pop_data   (pop_data),
        .rd_a_data  (rf_rd_a_data),
        .r3         (r3)
    );

    stack_ram u_stack_ram (
        .clk_100mhz (clk_100mhz),
        .req        (stack_req),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    seg_display u_seg_display (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .value      (r3),
        .seg_sel    (seg_sel),
        .seg_data   (seg_data)
    );

endmodule

/* bench/insn_exec_model.svh */
`ifndef INSN_EXEC_MODEL_SVH
`define INSN_EXEC_MODEL_SVH

// Reference machine state, carried from test to test like the DUT
word_t ref_regs [16];
word_t ref_mem  [2 ** `SP_W];
sp_t   ref_sp;

function automatic void clear_model();
    foreach (ref_regs[i]) ref_regs[i] = '0;
    foreach (ref_mem[i]) ref_mem[i] = '0;
    ref_sp = sp_t'(`STACK_BASE);    // Stack grows upward from here
endfunction

// Runs one instruction list on the model, gives the new r3
function automatic word_t run_program(input insn_t prog[$]);
    logic [1:0] op;
    logic [5:0] mod;
    reg_idx_t   src;
    reg_idx_t   dst;
    foreach (prog[i]) begin
        op  = prog[i][15:14];
        mod = prog[i][13:8];
        src = prog[i][7:4];     // Also the ADDI immediate
        dst = prog[i][3:0];
        if (op == OP_R) begin
            case (mod)
                RMOD_MOV:  ref_regs[dst] = ref_regs[src];
                RMOD_ADD:  ref_regs[dst] = ref_regs[dst] + ref_regs[src];  // Wraps at 16 bits
                RMOD_XOR:  ref_regs[dst] = ref_regs[dst] ^ ref_regs[src];
                RMOD_ADDI: ref_regs[dst] = ref_regs[dst] + word_t'(src);
                default:   ;    // Unknown mod, no effect
            endcase
        end else if (op == OP_M) begin
            if (mod == MMOD_PUSH) begin
                ref_mem[ref_sp] = ref_regs[dst];
                ref_sp = ref_sp + 1'b1;
            end else if (mod == MMOD_POP) begin
                ref_sp = ref_sp - 1'b1;     // Top of stack sits below sp
                ref_regs[dst] = ref_mem[ref_sp];
            end
        end
        // J and X families do nothing
    end
    return ref_regs[3];
endfunction

// Hex font, lit segments first, then flipped to active low with dp off
function automatic seg_t expected_seg(input logic [3:0] nib);
    logic [6:0] lit;    // gfedcba, 1 is on
    case (nib)
        4'h0: lit = 7'h3F;
        4'h1: lit = 7'h06;
        4'h2: lit = 7'h5B;
        4'h3: lit = 7'h4F;
        4'h4: lit = 7'h66;
        4'h5: lit = 7'h6D;
        4'h6: lit = 7'h7D;
        4'h7: lit = 7'h07;
        4'h8: lit = 7'h7F;
        4'h9: lit = 7'h6F;
        4'hA: lit = 7'h77;
        4'hB: lit = 7'h7C;  // Lower-case b
        4'hC: lit = 7'h39;
        4'hD: lit = 7'h5E;  // Lower-case d
        4'hE: lit = 7'h79;
        default: lit = 7'h71;   // F
    endcase
    return {1'b1, ~lit};
endfunction

`endif

/* bench/insn_exec_tb.sv */
`timescale 1ns/10ps
`include "insn_exec_config.svh"

module insn_exec_tb;
    import insn_exec_pkg::*;

    `include "insn_exec_model.svh"

    localparam int SCAN_CYCLES     = `SCAN_DIV * `NUM_DIGITS;  // One full display pass
    localparam int TEST_INSNS      = 26 + 12 + 5 + 40;         // Arith, stack, ignored, random
    localparam int TOTAL_BYTES     = 2 * TEST_INSNS;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 50 + 10 * SCAN_CYCLES;

    logic                   clk_100mhz = 1'b0;
    logic                   rst_n      = 1'b0;
    logic                   byte_valid = 1'b0;
    byte_t                  byte_data  = '0;
    logic [1:0]             credit_return;
    logic [`NUM_DIGITS-1:0] seg_sel;
    seg_t                   seg_data;

    byte_t  tx_q [$];                   // Bytes waiting to be sent
    int     credits    = `BYTE_CREDITS; // Sender's credit count
    bit     gap_en     = 1'b0;          // Random idle cycles between bytes
    integer seed       = 61;
    int     value_errs = 0;
    int     proto_errs = 0;

    insn_exec_top u_insn_exec_top (
        .clk_100mhz    (clk_100mhz),
        .rst_n         (rst_n),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .credit_return (credit_return),
        .seg_sel       (seg_sel),
        .seg_data      (seg_data)
    );

    always #5 clk_100mhz = ~clk_100mhz;

    // Credited sender spends one credit per byte
    always @(posedge clk_100mhz) begin
        int avail;
        avail = credits + int'(credit_return);
        assert (avail <= `BYTE_CREDITS) else begin
            proto_errs++;
            $display("Credit count rose to %0d, more than the sender started with", avail);
        end
        if (tx_q.size() != 0 && avail > 0 && !(gap_en && ($random(seed) & 3) == 0)) begin
            byte_valid <= 1'b1;
            byte_data  <= tx_q.pop_front();
            avail--;    // Spent on this byte
        end else begin
            byte_valid <= 1'b0;
        end
        credits <= avail;
    end

    // Select lines are one-cold at most
    always @(negedge clk_100mhz) begin
        if (rst_n) begin
            assert ($countones(~seg_sel) <= 1) else begin
                proto_errs++;
                $display("More than one digit select active at once");
            end
        end
    end

    function automatic insn_t encode_insn(input logic [1:0] op, input logic [5:0] mod,
                                          input reg_idx_t src, input reg_idx_t dst);
        return {op, mod, src, dst};
    endfunction

    // Sample a whole scan and compare each digit with the expected r3
    task automatic check_display(input string name, input word_t exp_r3);
        seg_t  seen [`NUM_DIGITS];
        bit    hit  [`NUM_DIGITS];
        seg_t  exp_seg;
        word_t rest;    // Remaining nibbles with the next digit on top
        foreach (hit[d]) hit[d] = 1'b0;
        rest = exp_r3;
        repeat (SCAN_CYCLES) begin
            @(negedge clk_100mhz);
            for (int d = 0; d < `NUM_DIGITS; d++) begin
                if (!seg_sel[d]) begin
                    seen[d] = seg_data;
                    hit[d]  = 1'b1;
                end
            end
        end
        for (int d = 0; d < `NUM_DIGITS; d++) begin
            exp_seg = expected_seg(rest[`DATA_W-1 -: 4]);  // Digit 0 is top nibble
            rest    = rest << 4;
            assert (hit[d]) else begin
                proto_errs++;
                $display("Digit %0d was never selected during %s", d, name);
            end
            assert (seen[d] === exp_seg) else begin
                value_errs++;
                $display("Error: %s digit %0d expected %h actual %h", name, d, exp_seg, seen[d]);
            end
        end
    endtask

    // Send a list and wait for every credit before checking r3
    task automatic run_test(input string name, input insn_t prog[$]);
        foreach (prog[i]) begin
            tx_q.push_back(prog[i][15:8]);  // High byte first
            tx_q.push_back(prog[i][7:0]);
        end
        @(negedge clk_100mhz);
        while (tx_q.size() != 0 || credits != `BYTE_CREDITS) @(negedge clk_100mhz);
        repeat (4) @(negedge clk_100mhz);   // Covers the pop write
        check_display(name, run_program(prog));
    endtask

    initial begin
        insn_t    prog [$];
        int       r;
        int       depth;
        reg_idx_t rd;
        reg_idx_t rs;
        clear_model();
        repeat (5) @(posedge clk_100mhz);
        rst_n <= 1'b1;
        @(negedge clk_100mhz);

        // Idle after reset
        repeat (SCAN_CYCLES) begin
            @(negedge clk_100mhz);
            assert (credit_return == 2'd0) else begin
                proto_errs++;
                $display("Credits returned with no bytes sent");
            end
        end
        check_display("reset", run_program(prog));

        // Arithmetic with wrap
        repeat (2) prog.push_back(encode_insn(OP_R, RMOD_ADDI, 4'd15, 4'd3));
        prog.push_back(encode_insn(OP_R, RMOD_ADDI, 4'd3, 4'd3));     // Past 16
        prog.push_back(encode_insn(OP_R, RMOD_MOV, 4'd3, 4'd5));
        repeat (11) prog.push_back(encode_insn(OP_R, RMOD_ADD, 4'd5, 4'd5));  // Shifts out the top
        prog.push_back(encode_insn(OP_R, RMOD_XOR, 4'd5, 4'd3));
        prog.push_back(encode_insn(OP_R, RMOD_ADDI, 4'd9, 4'd6));
        prog.push_back(encode_insn(OP_R, RMOD_ADD, 4'd6, 4'd3));
        repeat (5) prog.push_back(encode_insn(OP_R, RMOD_ADD, 4'd3, 4'd3));
        prog.push_back(encode_insn(OP_R, RMOD_MOV, 4'd3, 4'd7));
        prog.push_back(encode_insn(OP_R, RMOD_XOR, 4'd6, 4'd7));
        prog.push_back(encode_insn(OP_R, RMOD_MOV, 4'd7, 4'd3));
        run_test("arith", prog);

        // Three nested pushes popped back one at a time
        prog.delete();
        prog.push_back(encode_insn(OP_R, RMOD_ADDI, 4'd5, 4'd3));
        prog.push_back(encode_insn(OP_M, MMOD_PUSH, 4'd0, 4'd3));
        prog.push_back(encode_insn(OP_R, RMOD_ADDI, 4'd7, 4'd3));
        prog.push_back(encode_insn(OP_M, MMOD_PUSH, 4'd0, 4'd3));
        prog.push_back(encode_insn(OP_R, RMOD_XOR, 4'd3, 4'd3));      // Clear r3
        prog.push_back(encode_insn(OP_R, RMOD_ADDI, 4'd1, 4'd3));
        prog.push_back(encode_insn(OP_M, MMOD_PUSH, 4'd0, 4'd3));
        prog.push_back(encode_insn(OP_R, RMOD_ADDI, 4'd9, 4'd3));
        prog.push_back(encode_insn(OP_M, MMOD_POP, 4'd0, 4'd3));
        run_test("stack_pop_1", prog);
        prog.delete();
        prog.push_back(encode_insn(OP_R, RMOD_ADDI, 4'd2, 4'd3));
        prog.push_back(encode_insn(OP_M, MMOD_POP, 4'd0, 4'd3));
        run_test("stack_pop_2", prog);
        prog.delete();
        prog.push_back(encode_insn(OP_M, MMOD_POP, 4'd0, 4'd3));
        run_test("stack_pop_3", prog);

        // Reserved families and unknown mods, sources point at nonzero r6
        prog.delete();
        prog.push_back(encode_insn(OP_J, 6'h01, 4'd6, 4'd3));
        prog.push_back(encode_insn(OP_X, 6'h10, 4'hF, 4'd3));
        prog.push_back(encode_insn(OP_R, 6'h3F, 4'd6, 4'd3));
        prog.push_back(encode_insn(OP_R, 6'h02, 4'd6, 4'd3));
        prog.push_back(encode_insn(OP_M, 6'h01, 4'd0, 4'd3));
        run_test("ignored", prog);

        // Random mix with idle gaps and pops only while the stack holds data
        prog.delete();
        gap_en = 1'b1;
        depth  = 0;
        for (int n = 0; n < 40; n++) begin
            r  = $random(seed);
            rd = reg_idx_t'(r[6:4]);    // r0..r7 keeps r3 busy
            rs = reg_idx_t'(r[11:8]);
            case (r[2:0])
                3'd1: prog.push_back(encode_insn(OP_R, RMOD_MOV, rs, rd));
                3'd2: prog.push_back(encode_insn(OP_R, RMOD_ADD, rs, rd));
                3'd3: prog.push_back(encode_insn(OP_R, RMOD_XOR, rs, rd));
                3'd4: begin
                    prog.push_back(encode_insn(OP_M, MMOD_PUSH, rs, rd));
                    depth++;
                end
                3'd5: begin
                    if (depth > 0) begin
                        prog.push_back(encode_insn(OP_M, MMOD_POP, rs, rd));
                        depth--;
                    end else begin
                        prog.push_back(encode_insn(OP_R, RMOD_ADDI, rs, 4'd3));
                    end
                end
                3'd6: prog.push_back(encode_insn(OP_J, r[17:12], rs, rd));
                default: prog.push_back(encode_insn(OP_R, RMOD_ADDI, rs, rd));
            endcase
        end
        run_test("random", prog);

        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Run limit from the byte count and scan length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_100mhz);
        $display("Watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

/* insn_exec.f */
+incdir+logic
+incdir+bench
logic/insn_exec_pkg.sv
logic/insn_assembler.sv
logic/exec_control.sv
logic/reg_file_alu.sv
logic/stack_ram.sv
logic/seg_display.sv
logic/insn_exec_top.sv
bench/insn_exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the insn_exec testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f insn_exec.f \
    --top-module insn_exec_tb -o insn_exec_sim \
    || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/insn_exec_sim)
echo "$out"

echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
